// File: dv/tbInstrCache.sv
`timescale 1ns/1ps
/*
 * Instruction cache testbench with a residency and LRU model,
 * a Wishbone memory model and assertion checks on fetch and bus
 */
module tbInstrCache;

    localparam int          rngSeed     = 54;
    localparam int          stallLimit  = 200;
    localparam logic [31:0] scrambleKey = 32'hC0DE_0000;
    localparam int          wordShift   = 2 + $clog2(icachePkg::lineWords);
    localparam int          tagShift    = wordShift + icachePkg::setBits;
    localparam int          setCount    = 1 << icachePkg::setBits;

    logic        clk;
    logic        rstN;
    logic        fetchReq;
    logic [31:0] fetchAddr;
    logic        invalidate;
    logic [31:0] wbDatI;
    logic        wbAck;
    logic [31:0] rdData;
    logic        iStall;
    logic        wbCyc;
    logic        wbStb;
    logic [31:0] wbAdr;

    // Residency model with index 0 as way 1
    logic [icachePkg::tagBits-1:0] modelTag [2][setCount];
    logic modelValid [2][setCount];
    logic modelLru [setCount];

    // Bus monitor state
    logic [31:0] lineBase;
    logic        busExpected;
    int          ackCount;
    logic        prevStb;
    logic        prevAck;
    logic [31:0] prevAdr;

    instrCache i_instrCache (
        .clk       (clk       ),
        .rstN      (rstN      ),
        .fetchReq  (fetchReq  ),
        .fetchAddr (fetchAddr ),
        .invalidate(invalidate),
        .wbDatI    (wbDatI    ),
        .wbAck     (wbAck     ),
        .rdData    (rdData    ),
        .iStall    (iStall    ),
        .wbCyc     (wbCyc     ),
        .wbStb     (wbStb     ),
        .wbAdr     (wbAdr     )
    );

    wbMemoryModel #(.dataKey(scrambleKey)) memModel (
        .clk   (clk   ),
        .rstN  (rstN  ),
        .wbCyc (wbCyc ),
        .wbStb (wbStb ),
        .wbAdr (wbAdr ),
        .wbDatO(wbDatI),
        .wbAck (wbAck )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic reportMismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopped at first wrong value");
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Checks failed");
        $fatal(1, "stopped on timeout");
    endtask

    function automatic logic [31:0] memWord(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ scrambleKey;
    endfunction

    function automatic int setOf(input logic [31:0] addr);
        return int'(addr[wordShift +: icachePkg::setBits]);
    endfunction

    // Hitting way 0 or 1, or -1 on a miss
    function automatic int modelLookup(input logic [31:0] addr);
        int s;
        s = setOf(addr);
        for (int w = 0; w < 2; w++) begin
            if (modelValid[w][s] && modelTag[w][s] == addr[31 -: icachePkg::tagBits]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Invalid way 1, invalid way 2, then the LRU way
    task automatic modelAccess(input logic [31:0] addr);
        int s;
        int w;
        s = setOf(addr);
        w = modelLookup(addr);
        if (w < 0) begin
            if (!modelValid[0][s]) begin
                w = 0;
            end else if (!modelValid[1][s]) begin
                w = 1;
            end else begin
                w = int'(modelLru[s]);
            end
            modelTag[w][s]   = addr[31 -: icachePkg::tagBits];
            modelValid[w][s] = 1'b1;
        end
        modelLru[s] = (w == 0);
    endtask

    function automatic logic [31:0] randomAddr();
        logic [31:0] addr;
        addr = (32'(16 + $urandom % 3) << tagShift)
             | (32'($urandom % setCount) << wordShift)
             | (32'($urandom % icachePkg::lineWords) << 2);
        return addr;
    endfunction

    // Bus protocol and refill address checks
    always @(negedge clk) begin
        if (rstN) begin
            assert (wbStb === wbCyc) else reportMismatch("wbStb differs from wbCyc");
            assert (busExpected || wbCyc !== 1'b1) else reportMismatch("bus cycle on a hit");
            if (prevStb && !prevAck) begin
                assert (wbStb === 1'b1 && wbAdr === prevAdr)
                    else reportMismatch("wbStb or wbAdr changed before wbAck");
            end
            if (prevAck) begin
                assert (wbStb === 1'b0)
                    else reportMismatch("wbStb still high in the cycle after wbAck");
            end
            if (wbStb && wbAck) begin
                assert (wbAdr === lineBase + 32'(4 * ackCount))
                    else reportMismatch($sformatf("refill word %0d at wbAdr %h", ackCount, wbAdr));
                ackCount = ackCount + 1;
            end
        end
        prevStb = rstN && wbStb;
        prevAck = wbAck;
        prevAdr = wbAdr;
    end

    task automatic doFetch(input logic [31:0] addr);
        logic expectMiss;
        int waited;
        expectMiss = (modelLookup(addr) < 0);
        @(posedge clk);
        #2;
        fetchReq    = 1'b1;
        fetchAddr   = addr;
        lineBase    = addr & ~32'(icachePkg::lineWords * 4 - 1);
        busExpected = expectMiss;
        ackCount    = 0;
        @(negedge clk);
        assert (iStall === expectMiss)
            else reportMismatch($sformatf("iStall %b for %h, expected %b", iStall, addr, expectMiss));
        waited = 0;
        while (iStall !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > stallLimit) begin
                reportTimeout("iStall to fall after a miss");
            end
        end
        assert (ackCount == (expectMiss ? icachePkg::lineWords : 0))
            else reportMismatch($sformatf("%0d refill words for %h", ackCount, addr));
        assert (rdData === memWord(addr))
            else reportMismatch($sformatf("rdData %h for %h, expected %h", rdData, addr,
                                          memWord(addr)));
        modelAccess(addr);
    endtask

    task automatic pulseInvalidate();
        @(posedge clk);
        #2;
        fetchReq   = 1'b0;
        invalidate = 1'b1;
        @(posedge clk);
        #2;
        invalidate = 1'b0;
        for (int s = 0; s < setCount; s++) begin
            modelValid[0][s] = 1'b0;
            modelValid[1][s] = 1'b0;
        end
    endtask

    initial begin
        logic [31:0] addrA;
        logic [31:0] addrB;
        logic [31:0] addrC;
        fetchReq    = 1'b0;
        fetchAddr   = '0;
        invalidate  = 1'b0;
        rstN        = 1'b0;
        lineBase    = '0;
        busExpected = 1'b0;
        ackCount    = 0;
        for (int s = 0; s < setCount; s++) begin
            modelValid[0][s] = 1'b0;
            modelValid[1][s] = 1'b0;
            modelTag[0][s]   = '0;
            modelTag[1][s]   = '0;
            modelLru[s]      = 1'b0;
        end
        void'($urandom(rngSeed));
        addrA = 32'h0000_1008;
        addrB = addrA + (32'd1 << tagShift);
        addrC = addrA + (32'd2 << tagShift);

        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
        @(negedge clk);
        assert (iStall === 1'b0 && wbCyc === 1'b0 && wbStb === 1'b0)
            else reportMismatch("iStall, wbCyc or wbStb not low after reset");

        // First miss, then the rest of the line hits
        doFetch(addrA);
        for (int w = 0; w < icachePkg::lineWords; w++) begin
            doFetch(lineBase | 32'(w * 4));
        end

        // Two tags in one set stay resident
        doFetch(addrB);
        doFetch(addrA);
        doFetch(addrB);

        // Third tag evicts the LRU way
        doFetch(addrC);
        doFetch(addrB);
        doFetch(addrA);

        for (int i = 0; i < 40; i++) begin
            doFetch(randomAddr());
        end

        // Invalidate with line A resident
        doFetch(addrA);
        pulseInvalidate();
        doFetch(addrA);
        doFetch(addrA);

        @(posedge clk);
        #2;
        fetchReq = 1'b0;
        $display("All checks passed");
        $finish;
    end

endmodule

// File: dv/wbMemoryModel.sv
`timescale 1ns/1ps
/*
 * Wishbone classic read slave with random wait states
 * Each word returns its word address XOR a scramble key
 */
module wbMemoryModel #(
    parameter logic [31:0] dataKey = 32'h0
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic [31:0] wbAdr,
    output logic [31:0] wbDatO,
    output logic        wbAck
);

    logic       busy;
    logic [1:0] waitLeft;

    always @(posedge clk) begin
        if (!rstN) begin
            wbAck    <= 1'b0;
            wbDatO   <= '0;
            busy     <= 1'b0;
            waitLeft <= '0;
        end else if (wbAck) begin
            // Ack lasts one cycle, the master drops stb after it
            wbAck <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (!busy) begin
                // 0 to 3 wait states per word
                busy     <= 1'b1;
                waitLeft <= 2'($urandom % 4);
            end else if (waitLeft == 2'd0) begin
                busy   <= 1'b0;
                wbAck  <= 1'b1;
                wbDatO <= {2'b00, wbAdr[31:2]} ^ dataKey;
            end else begin
                waitLeft <= waitLeft - 2'd1;
            end
        end
    end

endmodule

// File: sim.f
verilog/icachePkg.sv
verilog/icacheMemory.sv
verilog/icacheController.sv
verilog/instrCache.sv
dv/wbMemoryModel.sv
dv/tbInstrCache.sv

// File: verilog/icacheController.sv
`timescale 1ns/1ps
/*
 * Instruction cache controller: hit detection, miss FSM and
 * Wishbone classic read master for line refills
 */
module icacheController (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             fetchReq,
    input  logic [icachePkg::tagBits-1:0]    reqTag,
    input  logic                             valid1,
    input  logic                             valid2,
    input  logic [icachePkg::tagBits-1:0]    tag1,
    input  logic [icachePkg::tagBits-1:0]    tag2,
    input  logic                             lruWay,
    input  logic                             wbAck,
    output logic                             iStall,
    output logic                             hitWay,
    output logic                             wbCyc,
    output logic                             wbStb,
    output logic [icachePkg::offsetBits-1:0] fillOffset,
    output logic                             wayWe1,
    output logic                             wayWe2,
    output logic                             tagWe,
    output logic                             lruTouch,
    output logic                             touchedWay
);

    icachePkg::ctrlState state;

    logic hit1;
    logic hit2;
    logic hit;
    logic miss;
    logic victim;
    logic victimNext;
    logic busActive;
    logic wordAck;
    logic lastWord;

    // Tag compare on both ways
    assign hit1   = valid1 && (tag1 == reqTag);
    assign hit2   = valid2 && (tag2 == reqTag);
    assign hit    = hit1 || hit2;
    assign hitWay = hit2;

    // Stall rises in the cycle the miss is seen
    assign miss   = (state == icachePkg::idle) && fetchReq && !hit;
    assign iStall = miss || (state != icachePkg::idle);

    // Invalid way 1, then invalid way 2, then the LRU way
    assign victimNext = !valid1 ? 1'b0 : (!valid2 ? 1'b1 : lruWay);

    // One classic cycle per word
    assign wbCyc    = busActive;
    assign wbStb    = busActive;
    assign wordAck  = busActive && wbAck;
    assign lastWord = (int'(fillOffset) == icachePkg::lineWords - 1);

    // Word writes into the victim, tag and valid with the last one
    assign wayWe1 = wordAck && !victim;
    assign wayWe2 = wordAck && victim;
    assign tagWe  = wordAck && lastWord;

    // Hit at the accepting edge, or completed refill
    assign lruTouch   = ((state == icachePkg::idle) && fetchReq && hit) || tagWe;
    assign touchedWay = (state == icachePkg::idle) ? hitWay : victim;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= icachePkg::idle;
            busActive  <= 1'b0;
            fillOffset <= '0;
            victim     <= 1'b0;
        end else begin
            case (state)
                icachePkg::idle: begin
                    if (miss) begin
                        victim     <= victimNext;
                        fillOffset <= '0;
                        busActive  <= 1'b1;
                        state      <= icachePkg::fill;
                    end
                end
                icachePkg::fill: begin
                    if (wordAck) begin
                        // Drop stb and cyc for one cycle between words
                        busActive <= 1'b0;
                        if (lastWord) begin
                            state <= icachePkg::settle;
                        end else begin
                            fillOffset <= fillOffset + 1'b1;
                        end
                    end else if (!busActive) begin
                        busActive <= 1'b1;
                    end
                end
                icachePkg::settle: begin
                    state <= icachePkg::idle;
                end
                default: begin
                    state     <= icachePkg::idle;
                    busActive <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: verilog/icacheMemory.sv
`timescale 1ns/1ps
/*
 * Instruction cache arrays: two ways of tag, valid and data storage
 * with one LRU bit per set, combinational reads and clocked writes
 */
module icacheMemory (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             invalidate,
    input  logic [icachePkg::setBits-1:0]    setIdx,
    input  logic [icachePkg::offsetBits-1:0] wordIdx,
    input  logic [icachePkg::offsetBits-1:0] fillOffset,
    input  logic [icachePkg::tagBits-1:0]    wrTag,
    input  logic [31:0]                      wrData,
    input  logic                             wayWe1,
    input  logic                             wayWe2,
    input  logic                             tagWe,
    input  logic                             lruTouch,
    input  logic                             touchedWay,
    output logic                             valid1,
    output logic                             valid2,
    output logic [icachePkg::tagBits-1:0]    tag1,
    output logic [icachePkg::tagBits-1:0]    tag2,
    output logic [31:0]                      data1,
    output logic [31:0]                      data2,
    output logic                             lruWay
);

    // Index 0 is way 1, index 1 is way 2
    logic [31:0] dataArr [2][icachePkg::numSets][icachePkg::lineWords];
    logic [icachePkg::tagBits-1:0] tagArr [2][icachePkg::numSets];
    logic [1:0][icachePkg::numSets-1:0] validBits;
    logic [icachePkg::numSets-1:0] lruBits;
    logic [1:0] wayWe;
    logic anyWe;
    logic invPending;

    assign wayWe = {wayWe2, wayWe1};
    assign anyWe = wayWe1 || wayWe2;

    // Lookup side
    assign valid1 = validBits[0][setIdx];
    assign valid2 = validBits[1][setIdx];
    assign tag1   = tagArr[0][setIdx];
    assign tag2   = tagArr[1][setIdx];
    assign data1  = dataArr[0][setIdx][wordIdx];
    assign data2  = dataArr[1][setIdx][wordIdx];
    assign lruWay = lruBits[setIdx];

    // Refill words and tag
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wayWe[w]) begin
                dataArr[w][setIdx][fillOffset] <= wrData;
                if (tagWe) begin
                    tagArr[w][setIdx] <= wrTag;
                end
            end
        end
    end

    // Valid bits, invalidate held back while a word is written
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validBits  <= '0;
            invPending <= 1'b0;
        end else if (anyWe) begin
            if (invalidate) begin
                invPending <= 1'b1;
            end
            for (int w = 0; w < 2; w++) begin
                if (wayWe[w] && tagWe) begin
                    validBits[w][setIdx] <= 1'b1;
                end
            end
        end else if (invalidate || invPending) begin
            validBits  <= '0;
            invPending <= 1'b0;
        end
    end

    // LRU bit names the way to replace next
    always_ff @(posedge clk) begin
        if (!rstN) begin
            lruBits <= '0;
        end else if (lruTouch) begin
            lruBits[setIdx] <= ~touchedWay;
        end
    end

endmodule

// File: verilog/icachePkg.sv
/*
 * Instruction cache package
 * Cache geometry, address field widths and controller states
 */
package icachePkg;

    // Line and set geometry
    localparam int lineWords = 4;
    localparam int numSets   = 8;

    // Address fields, word offset above the two byte bits
    localparam int offsetBits = $clog2(lineWords);
    localparam int setBits    = $clog2(numSets);
    localparam int tagBits    = 32 - 2 - offsetBits - setBits;

    // Controller states
    // idle serves lookups, fill runs the line refill and settle
    // gives the arrays one cycle before the lookup retries
    typedef enum logic [1:0] {
        idle   = 2'b00,
        fill   = 2'b01,
        settle = 2'b10
    } ctrlState;

endpackage

// File: verilog/instrCache.sv
`timescale 1ns/1ps
/*
 * 2-way set-associative read-only instruction cache
 * Fetch-side lookup with Wishbone classic line refill
 */
module instrCache (
    input  logic        clk,
    input  logic        rstN,
    input  logic        fetchReq,
    input  logic [31:0] fetchAddr,
    input  logic        invalidate,
    input  logic [31:0] wbDatI,
    input  logic        wbAck,
    output logic [31:0] rdData,
    output logic        iStall,
    output logic        wbCyc,
    output logic        wbStb,
    output logic [31:0] wbAdr
);

    logic [icachePkg::tagBits-1:0]    reqTag;
    logic [icachePkg::setBits-1:0]    setIdx;
    logic [icachePkg::offsetBits-1:0] wordIdx;
    logic [icachePkg::offsetBits-1:0] fillOffset;
    logic [icachePkg::tagBits-1:0]    tag1;
    logic [icachePkg::tagBits-1:0]    tag2;
    logic [31:0] data1;
    logic [31:0] data2;
    logic valid1;
    logic valid2;
    logic lruWay;
    logic hitWay;
    logic wayWe1;
    logic wayWe2;
    logic tagWe;
    logic lruTouch;
    logic touchedWay;

    // Address split: tag, set, word, byte
    assign wordIdx = fetchAddr[icachePkg::offsetBits+1:2];
    assign setIdx  = fetchAddr[icachePkg::offsetBits+2 +: icachePkg::setBits];
    assign reqTag  = fetchAddr[31 -: icachePkg::tagBits];

    // Refill address walks the line from word 0
    assign wbAdr = {reqTag, setIdx, fillOffset, 2'b00};

    icacheMemory memory (
        .clk       (clk       ),
        .rstN      (rstN      ),
        .invalidate(invalidate),
        .setIdx    (setIdx    ),
        .wordIdx   (wordIdx   ),
        .fillOffset(fillOffset),
        .wrTag     (reqTag    ),
        .wrData    (wbDatI    ),
        .wayWe1    (wayWe1    ),
        .wayWe2    (wayWe2    ),
        .tagWe     (tagWe     ),
        .lruTouch  (lruTouch  ),
        .touchedWay(touchedWay),
        .valid1    (valid1    ),
        .valid2    (valid2    ),
        .tag1      (tag1      ),
        .tag2      (tag2      ),
        .data1     (data1     ),
        .data2     (data2     ),
        .lruWay    (lruWay    )
    );

    icacheController controller (
        .clk       (clk       ),
        .rstN      (rstN      ),
        .fetchReq  (fetchReq  ),
        .reqTag    (reqTag    ),
        .valid1    (valid1    ),
        .valid2    (valid2    ),
        .tag1      (tag1      ),
        .tag2      (tag2      ),
        .lruWay    (lruWay    ),
        .wbAck     (wbAck     ),
        .iStall    (iStall    ),
        .hitWay    (hitWay    ),
        .wbCyc     (wbCyc     ),
        .wbStb     (wbStb     ),
        .fillOffset(fillOffset),
        .wayWe1    (wayWe1    ),
        .wayWe2    (wayWe2    ),
        .tagWe     (tagWe     ),
        .lruTouch  (lruTouch  ),
        .touchedWay(touchedWay)
    );

    // Way mux
    assign rdData = hitWay ? data2 : data1;

endmodule
